// File: flist.f
source/riscv_de_pkg.sv
source/riscv_de_regfile.sv
source/riscv_de_decoder.sv
source/riscv_de_ppreg.sv
source/riscv_de_div_timer.sv
source/riscv_de_hazard_fsm.sv
source/riscv_de_top.sv
verif/riscv_de_tb.sv

// File: source/riscv_de_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_decoder (
    input  wire riscv_de_pkg::inst_t    i_riscv_de_inst,
    input  wire logic                   i_riscv_de_inst_valid,
    output riscv_de_pkg::de_ctrl_t      o_riscv_de_ctrl,
    output riscv_de_pkg::xlen_t         o_riscv_de_imm,
    output riscv_de_pkg::regaddr_t      o_riscv_de_rs1addr,
    output riscv_de_pkg::regaddr_t      o_riscv_de_rs2addr,
    output riscv_de_pkg::regaddr_t      o_riscv_de_rdaddr
);

    riscv_de_pkg::opcode_e  opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    riscv_de_pkg::xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
    riscv_de_pkg::de_ctrl_t ctrl;
    logic                   rs1_used;
    logic                   rs2_used;

    function automatic riscv_de_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? riscv_de_pkg::ALU_SUB : riscv_de_pkg::ALU_ADD;
            3'b001:  return riscv_de_pkg::ALU_SLL;
            3'b010:  return riscv_de_pkg::ALU_SLT;
            3'b011:  return riscv_de_pkg::ALU_SLTU;
            3'b100:  return riscv_de_pkg::ALU_XOR;
            3'b101:  return alt ? riscv_de_pkg::ALU_SRA : riscv_de_pkg::ALU_SRL;
            3'b110:  return riscv_de_pkg::ALU_OR;
            default: return riscv_de_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = riscv_de_pkg::opcode_e'(i_riscv_de_inst[6:0]);
    assign funct3 = i_riscv_de_inst[14:12];
    assign funct7 = i_riscv_de_inst[31:25];

    assign imm_i = {{52{i_riscv_de_inst[31]}}, i_riscv_de_inst[31:20]};
    assign imm_s = {{52{i_riscv_de_inst[31]}}, i_riscv_de_inst[31:25], i_riscv_de_inst[11:7]};
    assign imm_b = {{51{i_riscv_de_inst[31]}}, i_riscv_de_inst[31], i_riscv_de_inst[7],
                    i_riscv_de_inst[30:25], i_riscv_de_inst[11:8], 1'b0};
    assign imm_u = {{32{i_riscv_de_inst[31]}}, i_riscv_de_inst[31:12], 12'b0};
    assign imm_j = {{43{i_riscv_de_inst[31]}}, i_riscv_de_inst[31], i_riscv_de_inst[19:12],
                    i_riscv_de_inst[20], i_riscv_de_inst[30:21], 1'b0};

    always_comb
    begin
        ctrl     = '0;
        o_riscv_de_imm = '0;
        rs1_used = 1'b1;
        rs2_used = 1'b0;
        case (opcode)
            riscv_de_pkg::OPC_OP:
            begin
                ctrl.regwrite = 1'b1;
                rs2_used      = 1'b1;
                if (funct7 == 7'b0000001 && funct3[2])
                begin
                    case (funct3[1:0])
                        2'b00:   ctrl.divctrl = riscv_de_pkg::DIV_DIV;
                        2'b01:   ctrl.divctrl = riscv_de_pkg::DIV_DIVU;
                        2'b10:   ctrl.divctrl = riscv_de_pkg::DIV_REM;
                        default: ctrl.divctrl = riscv_de_pkg::DIV_REMU;
                    endcase
                end
                else if (funct7 == 7'b0000001)
                begin
                    ctrl.mul          = 1'b1;
                    ctrl.illegal_inst = (funct3 != 3'b000);  // Only MUL in this subset
                end
                else
                begin
                    ctrl.alucontrol = alu_sel(funct3, i_riscv_de_inst[30]);
                end
            end
            riscv_de_pkg::OPC_OP_IMM:
            begin
                ctrl.regwrite   = 1'b1;
                ctrl.oprnd2sel  = 1'b1;
                ctrl.alucontrol = alu_sel(funct3, i_riscv_de_inst[30] && funct3 == 3'b101);
                o_riscv_de_imm  = imm_i;
            end
            riscv_de_pkg::OPC_LOAD:
            begin
                ctrl.regwrite  = 1'b1;
                ctrl.memread   = 1'b1;
                ctrl.oprnd2sel = 1'b1;
                ctrl.memext    = funct3;
                ctrl.resultsrc = 2'b01;
                o_riscv_de_imm = imm_i;
            end
            riscv_de_pkg::OPC_STORE:
            begin
                ctrl.memwrite  = 1'b1;
                ctrl.oprnd2sel = 1'b1;
                ctrl.memext    = funct3;
                rs2_used       = 1'b1;
                o_riscv_de_imm = imm_s;
            end
            riscv_de_pkg::OPC_BRANCH:
            begin
                ctrl.alucontrol  = riscv_de_pkg::ALU_SUB;  // Compare in the ALU
                ctrl.b_condition = funct3;
                rs2_used         = 1'b1;
                o_riscv_de_imm   = imm_b;
            end
            riscv_de_pkg::OPC_JAL:
            begin
                ctrl.regwrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.oprnd1sel = 1'b1;
                ctrl.oprnd2sel = 1'b1;
                ctrl.resultsrc = 2'b10;
                rs1_used       = 1'b0;
                o_riscv_de_imm = imm_j;
            end
            riscv_de_pkg::OPC_LUI:
            begin
                ctrl.regwrite   = 1'b1;
                ctrl.oprnd2sel  = 1'b1;
                ctrl.alucontrol = riscv_de_pkg::ALU_COPYB;
                rs1_used        = 1'b0;
                o_riscv_de_imm  = imm_u;
            end
            default:
            begin
                ctrl.illegal_inst = 1'b1;
                rs1_used          = 1'b0;
            end
        endcase

        if (ctrl.illegal_inst)
        begin
            ctrl.regwrite = 1'b0;
            ctrl.memread  = 1'b0;
            ctrl.memwrite = 1'b0;
        end
        if (!i_riscv_de_inst_valid)
        begin
            ctrl           = '0;
            o_riscv_de_imm = '0;
            rs1_used       = 1'b0;
            rs2_used       = 1'b0;
        end
    end

    assign o_riscv_de_ctrl    = ctrl;
    // Unused source fields read as x0 so they cannot raise a load-use stall
    assign o_riscv_de_rs1addr = rs1_used ? i_riscv_de_inst[19:15] : '0;
    assign o_riscv_de_rs2addr = rs2_used ? i_riscv_de_inst[24:20] : '0;
    assign o_riscv_de_rdaddr  = i_riscv_de_inst[11:7];

endmodule

`default_nettype wire

// File: source/riscv_de_div_timer.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_div_timer #(
    parameter int unsigned DIV_LATENCY = 8
) (
    input  wire logic i_riscv_de_clk,
    input  wire logic i_riscv_de_rst,
    input  wire logic i_riscv_de_start,
    input  wire logic i_riscv_de_clear,
    output logic      o_riscv_de_done
);

    localparam int unsigned CNT_W = $clog2(DIV_LATENCY);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DIV_LATENCY - 2);

    logic [CNT_W-1:0] count_q;
    logic             active_q;

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
        begin
            count_q  <= '0;
            active_q <= 1'b0;
        end
        else if (i_riscv_de_clear)
        begin
            count_q  <= '0;
            active_q <= 1'b0;
        end
        else if (i_riscv_de_start)
        begin
            count_q  <= CNT_MAX;  // Start cycle is the first busy cycle
            active_q <= 1'b1;
        end
        else if (active_q)
        begin
            if (count_q == '0)
                active_q <= 1'b0;
            else
                count_q <= count_q - 1'b1;
        end
    end

    assign o_riscv_de_done = active_q && (count_q == '0);

    a_count_bound: assert property (@(posedge i_riscv_de_clk)
        disable iff (i_riscv_de_rst || i_riscv_de_clear)
        i_riscv_de_start |=> (count_q <= CNT_MAX) until o_riscv_de_done);

endmodule

`default_nettype wire

// File: source/riscv_de_hazard_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_hazard_fsm #(
    parameter int unsigned DIV_LATENCY = 8
) (
    input  wire logic                   i_riscv_de_clk,
    input  wire logic                   i_riscv_de_rst,
    input  wire logic                   i_riscv_de_flush,
    input  wire riscv_de_pkg::de_ctrl_t i_riscv_de_ctrl_e,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_rdaddr_e,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_rs1addr_d,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_rs2addr_d,
    input  wire logic                   i_riscv_de_valid_d,
    input  wire logic                   i_riscv_de_div_done,
    output logic                        o_riscv_de_stall,
    output logic                        o_riscv_de_bubble,
    output logic                        o_riscv_de_div_start
);

    riscv_de_pkg::hz_state_e state_q, state_d;
    logic                    div_in_e;
    logic                    load_use;

    assign div_in_e = (i_riscv_de_ctrl_e.divctrl != riscv_de_pkg::DIV_NONE);
    assign load_use = i_riscv_de_ctrl_e.memread && i_riscv_de_valid_d &&
                      (i_riscv_de_rdaddr_e != '0) &&
                      (i_riscv_de_rdaddr_e == i_riscv_de_rs1addr_d ||
                       i_riscv_de_rdaddr_e == i_riscv_de_rs2addr_d);

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
            state_q <= riscv_de_pkg::HZ_RUN;
        else
            state_q <= state_d;
    end

    // Hazards are seen in RUN and answered in the same cycle
    always_comb
    begin
        state_d              = state_q;
        o_riscv_de_stall     = 1'b0;
        o_riscv_de_bubble    = 1'b0;
        o_riscv_de_div_start = 1'b0;
        case (state_q)
            riscv_de_pkg::HZ_RUN:
            begin
                if (div_in_e)
                begin
                    state_d              = riscv_de_pkg::HZ_DIV_BUSY;
                    o_riscv_de_stall     = 1'b1;
                    o_riscv_de_div_start = 1'b1;
                end
                else if (load_use)
                begin
                    state_d           = riscv_de_pkg::HZ_LOAD_BUBBLE;
                    o_riscv_de_bubble = 1'b1;
                end
            end
            riscv_de_pkg::HZ_LOAD_BUBBLE:
                state_d = riscv_de_pkg::HZ_RUN;  // Bubble sits in execute
            riscv_de_pkg::HZ_DIV_BUSY:
            begin
                if (i_riscv_de_div_done)
                    state_d = riscv_de_pkg::HZ_RUN;
                else
                    o_riscv_de_stall = 1'b1;
            end
            default:
                state_d = riscv_de_pkg::HZ_RUN;
        endcase
        if (i_riscv_de_flush)
        begin
            state_d              = riscv_de_pkg::HZ_RUN;
            o_riscv_de_stall     = 1'b0;
            o_riscv_de_bubble    = 1'b0;
            o_riscv_de_div_start = 1'b0;
        end
    end

    // Register keeps the divide in execute while busy
    a_div_hold_only: assert property (@(posedge i_riscv_de_clk)
        disable iff (i_riscv_de_rst || i_riscv_de_flush)
        (state_q == riscv_de_pkg::HZ_DIV_BUSY) |-> div_in_e);

    // Timer must release the FSM after exactly DIV_LATENCY-1 busy cycles
    a_div_length: assert property (@(posedge i_riscv_de_clk)
        disable iff (i_riscv_de_rst || i_riscv_de_flush)
        o_riscv_de_div_start |=> (state_q == riscv_de_pkg::HZ_DIV_BUSY) [*DIV_LATENCY-1]
        ##1 (state_q == riscv_de_pkg::HZ_RUN));

endmodule

`default_nettype wire

// File: source/riscv_de_pkg.sv
`default_nettype none

package riscv_de_pkg;

    localparam int unsigned XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      regaddr_t;
    typedef logic [31:0]     inst_t;

    // Major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_ILLEGAL = 7'b0000000,
        OPC_LOAD    = 7'b0000011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_STORE   = 7'b0100011,
        OPC_OP      = 7'b0110011,
        OPC_LUI     = 7'b0110111,
        OPC_BRANCH  = 7'b1100011,
        OPC_JAL     = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_COPYB = 4'd10   // Operand 2 straight through, LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        DIV_NONE = 3'd0,
        DIV_DIV  = 3'd1,
        DIV_DIVU = 3'd2,
        DIV_REM  = 3'd3,
        DIV_REMU = 3'd4
    } div_op_e;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e    alucontrol;
        logic       oprnd1sel;      // 1 selects PC
        logic       oprnd2sel;      // 1 selects immediate
        logic       memread;
        logic       memwrite;
        logic [2:0] memext;         // Load/store funct3
        logic [1:0] resultsrc;      // 00 ALU, 01 memory, 10 pc+4
        logic       regwrite;
        logic       jump;
        logic [2:0] b_condition;
        logic       mul;
        div_op_e    divctrl;
        logic       illegal_inst;
    } de_ctrl_t;

    typedef struct packed {
        xlen_t    pc;
        xlen_t    pcplus4;
        xlen_t    rs1data;
        xlen_t    rs2data;
        xlen_t    extendedimm;
        regaddr_t rs1addr;
        regaddr_t rs2addr;
        regaddr_t rdaddr;
    } de_data_t;

    typedef enum logic [1:0] {
        HZ_RUN         = 2'd0,
        HZ_LOAD_BUBBLE = 2'd1,
        HZ_DIV_BUSY    = 2'd2
    } hz_state_e;

endpackage

`default_nettype wire

// File: source/riscv_de_ppreg.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_ppreg (
    input  wire logic                   i_riscv_de_clk,
    input  wire logic                   i_riscv_de_rst,
    input  wire logic                   i_riscv_de_flush,
    input  wire logic                   i_riscv_de_stall,
    input  wire logic                   i_riscv_de_bubble,
    input  wire riscv_de_pkg::de_ctrl_t i_riscv_de_ctrl_d,
    input  wire riscv_de_pkg::de_data_t i_riscv_de_data_d,
    output riscv_de_pkg::de_ctrl_t      o_riscv_de_ctrl_e,
    output riscv_de_pkg::de_data_t      o_riscv_de_data_e
);

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
        begin
            o_riscv_de_ctrl_e <= '0;
            o_riscv_de_data_e <= '0;
        end
        else if (i_riscv_de_flush || (i_riscv_de_bubble && !i_riscv_de_stall))
        begin
            o_riscv_de_ctrl_e <= '0;  // Bubble
            o_riscv_de_data_e <= '0;
        end
        else if (!i_riscv_de_stall)
        begin
            o_riscv_de_ctrl_e <= i_riscv_de_ctrl_d;
            o_riscv_de_data_e <= i_riscv_de_data_d;
        end
    end

    a_flush_kills_write: assert property (@(posedge i_riscv_de_clk)
        disable iff (i_riscv_de_rst)
        i_riscv_de_flush |=> !o_riscv_de_ctrl_e.regwrite);

endmodule

`default_nettype wire

// File: source/riscv_de_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_regfile (
    input  wire logic                   i_riscv_de_clk,
    input  wire logic                   i_riscv_de_rst,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_rs1addr,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_rs2addr,
    input  wire logic                   i_riscv_de_wr_en,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_wr_addr,
    input  wire riscv_de_pkg::xlen_t    i_riscv_de_wr_data,
    output riscv_de_pkg::xlen_t         o_riscv_de_rs1data,
    output riscv_de_pkg::xlen_t         o_riscv_de_rs2data
);

    riscv_de_pkg::xlen_t regs [0:31];
    logic                wr_live;

    assign wr_live = i_riscv_de_wr_en && (i_riscv_de_wr_addr != '0);

    always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
    begin
        if (i_riscv_de_rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
        begin
            regs[i_riscv_de_wr_addr] <= i_riscv_de_wr_data;  // x0 never written
        end
    end

    // Write-back bypass ahead of the array
    assign o_riscv_de_rs1data = (wr_live && i_riscv_de_wr_addr == i_riscv_de_rs1addr) ?
                                i_riscv_de_wr_data : regs[i_riscv_de_rs1addr];
    assign o_riscv_de_rs2data = (wr_live && i_riscv_de_wr_addr == i_riscv_de_rs2addr) ?
                                i_riscv_de_wr_data : regs[i_riscv_de_rs2addr];

    a_x0_stays_zero: assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
        (i_riscv_de_rs1addr != '0 || o_riscv_de_rs1data == '0) &&
        (i_riscv_de_rs2addr != '0 || o_riscv_de_rs2data == '0));

endmodule

`default_nettype wire

// File: source/riscv_de_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_top #(
    parameter int unsigned DIV_LATENCY = 8
) (
    input  wire logic                   i_riscv_de_clk,
    input  wire logic                   i_riscv_de_rst,
    input  wire riscv_de_pkg::inst_t    i_riscv_de_inst,
    input  wire riscv_de_pkg::xlen_t    i_riscv_de_pc,
    input  wire logic                   i_riscv_de_inst_valid,
    input  wire logic                   i_riscv_de_wb_regwrite,
    input  wire riscv_de_pkg::regaddr_t i_riscv_de_wb_rdaddr,
    input  wire riscv_de_pkg::xlen_t    i_riscv_de_wb_data,
    input  wire logic                   i_riscv_de_flush,
    output riscv_de_pkg::de_ctrl_t      o_riscv_de_ctrl_e,
    output riscv_de_pkg::de_data_t      o_riscv_de_data_e,
    output logic                        o_riscv_de_stall_f
);

    riscv_de_pkg::de_ctrl_t ctrl_d;
    riscv_de_pkg::de_data_t data_d;
    riscv_de_pkg::xlen_t    imm_d, rs1data_d, rs2data_d;
    riscv_de_pkg::regaddr_t rs1addr_d, rs2addr_d, rdaddr_d;
    logic                   hz_stall, hz_bubble, div_start, div_done;

    riscv_de_regfile u_regfile (
        .i_riscv_de_clk     (i_riscv_de_clk),
        .i_riscv_de_rst     (i_riscv_de_rst),
        .i_riscv_de_rs1addr (rs1addr_d),
        .i_riscv_de_rs2addr (rs2addr_d),
        .i_riscv_de_wr_en   (i_riscv_de_wb_regwrite),
        .i_riscv_de_wr_addr (i_riscv_de_wb_rdaddr),
        .i_riscv_de_wr_data (i_riscv_de_wb_data),
        .o_riscv_de_rs1data (rs1data_d),
        .o_riscv_de_rs2data (rs2data_d)
    );

    riscv_de_decoder u_decoder (
        .i_riscv_de_inst       (i_riscv_de_inst),
        .i_riscv_de_inst_valid (i_riscv_de_inst_valid),
        .o_riscv_de_ctrl       (ctrl_d),
        .o_riscv_de_imm        (imm_d),
        .o_riscv_de_rs1addr    (rs1addr_d),
        .o_riscv_de_rs2addr    (rs2addr_d),
        .o_riscv_de_rdaddr     (rdaddr_d)
    );

    assign data_d = '{pc: i_riscv_de_pc, pcplus4: i_riscv_de_pc + riscv_de_pkg::xlen_t'(4),
                      rs1data: rs1data_d, rs2data: rs2data_d, extendedimm: imm_d,
                      rs1addr: rs1addr_d, rs2addr: rs2addr_d, rdaddr: rdaddr_d};

    riscv_de_hazard_fsm #(.DIV_LATENCY(DIV_LATENCY)) u_hazard_fsm (
        .i_riscv_de_clk       (i_riscv_de_clk),
        .i_riscv_de_rst       (i_riscv_de_rst),
        .i_riscv_de_flush     (i_riscv_de_flush),
        .i_riscv_de_ctrl_e    (o_riscv_de_ctrl_e),
        .i_riscv_de_rdaddr_e  (o_riscv_de_data_e.rdaddr),
        .i_riscv_de_rs1addr_d (rs1addr_d),
        .i_riscv_de_rs2addr_d (rs2addr_d),
        .i_riscv_de_valid_d   (i_riscv_de_inst_valid),
        .i_riscv_de_div_done  (div_done),
        .o_riscv_de_stall     (hz_stall),
        .o_riscv_de_bubble    (hz_bubble),
        .o_riscv_de_div_start (div_start)
    );

    riscv_de_div_timer #(.DIV_LATENCY(DIV_LATENCY)) u_div_timer (
        .i_riscv_de_clk   (i_riscv_de_clk),
        .i_riscv_de_rst   (i_riscv_de_rst),
        .i_riscv_de_start (div_start),
        .i_riscv_de_clear (i_riscv_de_flush),
        .o_riscv_de_done  (div_done)
    );

    riscv_de_ppreg u_ppreg (
        .i_riscv_de_clk    (i_riscv_de_clk),
        .i_riscv_de_rst    (i_riscv_de_rst),
        .i_riscv_de_flush  (i_riscv_de_flush),
        .i_riscv_de_stall  (hz_stall),
        .i_riscv_de_bubble (hz_bubble),
        .i_riscv_de_ctrl_d (ctrl_d),
        .i_riscv_de_data_d (data_d),
        .o_riscv_de_ctrl_e (o_riscv_de_ctrl_e),
        .o_riscv_de_data_e (o_riscv_de_data_e)
    );

    // Fetch holds for the load bubble as well as for a divide
    assign o_riscv_de_stall_f = hz_stall | hz_bubble;

endmodule

`default_nettype wire

// File: verif/riscv_de_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_de_tb;

    localparam int unsigned DIV_LATENCY  = 8;
    localparam int unsigned RESET_CYCLES = 16;
    localparam int          CLK_HALF     = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam int          SAMPLE_DLY   = 18;   // Mid cycle, for stall
    localparam string       TRACE_PATH   = "verif/riscv_de_trace.txt";

    // One trace line: inputs for a cycle and what should follow
    typedef struct packed {
        riscv_de_pkg::inst_t    inst;
        riscv_de_pkg::xlen_t    pc;
        logic                   valid;
        logic                   wb_regwrite;
        riscv_de_pkg::regaddr_t wb_rdaddr;
        riscv_de_pkg::xlen_t    wb_data;
        logic                   flush;
        riscv_de_pkg::de_ctrl_t exp_ctrl;
        riscv_de_pkg::de_data_t exp_data;
        logic                   exp_stall;
    } trace_rec_t;

    logic                   clk;
    logic                   rst;
    riscv_de_pkg::inst_t    inst;
    riscv_de_pkg::xlen_t    pc;
    logic                   inst_valid;
    logic                   wb_regwrite;
    riscv_de_pkg::regaddr_t wb_rdaddr;
    riscv_de_pkg::xlen_t    wb_data;
    logic                   flush;
    riscv_de_pkg::de_ctrl_t ctrl_e;
    riscv_de_pkg::de_data_t data_e;
    logic                   stall_f;

    trace_rec_t  trace_q [$];
    int unsigned timeout_cycles = 0;
    int unsigned cycle_count    = 0;
    int unsigned checks_done    = 0;
    int unsigned ctrl_errors    = 0;
    int unsigned data_errors    = 0;
    int unsigned stall_errors   = 0;
    int unsigned other_errors   = 0;

    riscv_de_top #(.DIV_LATENCY(DIV_LATENCY)) DUT (
        .i_riscv_de_clk         (clk),
        .i_riscv_de_rst         (rst),
        .i_riscv_de_inst        (inst),
        .i_riscv_de_pc          (pc),
        .i_riscv_de_inst_valid  (inst_valid),
        .i_riscv_de_wb_regwrite (wb_regwrite),
        .i_riscv_de_wb_rdaddr   (wb_rdaddr),
        .i_riscv_de_wb_data     (wb_data),
        .i_riscv_de_flush       (flush),
        .o_riscv_de_ctrl_e      (ctrl_e),
        .o_riscv_de_data_e      (data_e),
        .o_riscv_de_stall_f     (stall_f)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles != 0 && cycle_count >= timeout_cycles)
        begin
            $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [63:0] fld [0:16];
        trace_rec_t  rec;
        ok      = 1'b0;
        line_no = 0;
        fd      = $fopen(TRACE_PATH, "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file %s", TRACE_PATH);
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 8 || line.getc(0) == "#")
                continue;  // Header or blank line
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                        fld[15], fld[16]);
            if (n != 17)
            begin
                $display("Trace line %0d does not hold 17 fields", line_no);
                other_errors++;
                continue;
            end
            rec.inst                 = fld[0][31:0];
            rec.pc                   = fld[1];
            rec.valid                = fld[2][0];
            rec.wb_regwrite          = fld[3][0];
            rec.wb_rdaddr            = fld[4][4:0];
            rec.wb_data              = fld[5];
            rec.flush                = fld[6][0];
            rec.exp_ctrl             = fld[7][$bits(riscv_de_pkg::de_ctrl_t)-1:0];
            rec.exp_data.pc          = fld[8];
            rec.exp_data.pcplus4     = fld[9];
            rec.exp_data.rs1data     = fld[10];
            rec.exp_data.rs2data     = fld[11];
            rec.exp_data.extendedimm = fld[12];
            rec.exp_data.rs1addr     = fld[13][4:0];
            rec.exp_data.rs2addr     = fld[14][4:0];
            rec.exp_data.rdaddr      = fld[15][4:0];
            rec.exp_stall            = fld[16][0];
            trace_q.push_back(rec);
        end
        $fclose(fd);
        ok = (trace_q.size() > 0);
    endtask

    task automatic drive_inputs(input trace_rec_t rec);
        inst        = rec.inst;
        pc          = rec.pc;
        inst_valid  = rec.valid;
        wb_regwrite = rec.wb_regwrite;
        wb_rdaddr   = rec.wb_rdaddr;
        wb_data     = rec.wb_data;
        flush       = rec.flush;
    endtask

    task automatic check_ctrl(input riscv_de_pkg::de_ctrl_t got,
                              input riscv_de_pkg::de_ctrl_t exp, input string where);
        checks_done++;
        if (got !== exp)
        begin
            ctrl_errors++;
            $display("CHECK FAILED %s o_riscv_de_ctrl_e got %h expected %h", where, got, exp);
        end
    endtask

    task automatic check_data(input riscv_de_pkg::de_data_t got,
                              input riscv_de_pkg::de_data_t exp, input string where);
        checks_done++;
        if (got !== exp)
        begin
            data_errors++;
            $display("CHECK FAILED %s o_riscv_de_data_e got %h expected %h", where, got, exp);
        end
    endtask

    task automatic check_stall(input logic got, input logic exp, input string where);
        checks_done++;
        if (got !== exp)
        begin
            stall_errors++;
            $display("CHECK FAILED %s o_riscv_de_stall_f got %h expected %h", where, got, exp);
        end
    endtask

    task automatic run_trace();
        int n;
        n = trace_q.size();
        for (int i = 0; i <= n; i++)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            if (i > 0)  // Registered result of the previous record
            begin
                check_ctrl(ctrl_e, trace_q[i-1].exp_ctrl, $sformatf("record %0d", i - 1));
                check_data(data_e, trace_q[i-1].exp_data, $sformatf("record %0d", i - 1));
            end
            if (i < n)
            begin
                drive_inputs(trace_q[i]);
                #SAMPLE_DLY;
                check_stall(stall_f, trace_q[i].exp_stall, $sformatf("record %0d", i));
            end
        end
    endtask

    initial
    begin
        bit ok;
        rst         = 1'b1;
        inst        = '0;
        pc          = '0;
        inst_valid  = 1'b0;
        wb_regwrite = 1'b0;
        wb_rdaddr   = '0;
        wb_data     = '0;
        flush       = 1'b0;
        load_trace(ok);
        timeout_cycles = trace_q.size() + RESET_CYCLES + DIV_LATENCY * 4;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_stall(stall_f, 1'b0, "after reset");
        check_ctrl(ctrl_e, '0, "after reset");
        check_data(data_e, '0, "after reset");
        if (!ok)
        begin
            $display("The trace file holds no usable records");
            other_errors++;
        end
        else
        begin
            run_trace();
        end
        $display("Errors in %0d checks: ctrl %0d, data %0d, stall %0d, other %0d",
                 checks_done, ctrl_errors, data_errors, stall_errors, other_errors);
        if (ctrl_errors + data_errors + stall_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/riscv_de_trace.txt
# inst pc valid wb_we wb_rd wb_data flush ctrl pc pcplus4 rs1data rs2data imm rs1 rs2 rd stall
# Stall is this cycle's value; ctrl and data are the outputs after the next rising edge
00000013 1000 0 1 01 1111 0 000000 1000 1004 0 0 0 00 00 00 0
002081b3 1004 1 1 02 2222 0 000200 1004 1008 1111 2222 0 01 02 03 0
40110233 1008 1 0 00 0 0 080200 1008 100c 2222 1111 0 02 01 04 0
ff008293 100c 1 0 00 0 0 020200 100c 1010 1111 0 fffffffffffffff0 01 00 05 0
40315313 1010 1 0 00 0 0 3a0200 1010 1014 2222 0 403 02 00 06 0
00100433 1014 1 1 00 beef 0 000200 1014 1018 0 1111 0 00 01 08 0
800003b7 1018 1 0 00 0 0 520200 1018 101c 0 0 ffffffff80000000 00 00 07 0
fe20bc23 101c 1 0 00 0 0 02b000 101c 1020 1111 2222 fffffffffffffff8 01 02 18 0
fe209ee3 1020 1 0 00 0 0 080020 1020 1024 1111 2222 fffffffffffffffc 01 02 1d 0
010000ef 1024 1 0 00 0 0 060b00 1024 1028 0 0 10 00 00 01 0
ffffffff 1028 1 0 00 0 0 000001 1028 102c 0 0 0 00 00 1f 0
022084b3 102c 1 0 00 0 0 000210 102c 1030 1111 2222 0 01 02 09 0
0080b503 1030 1 0 00 0 0 033600 1030 1034 1111 0 8 01 00 0a 0
002505b3 1034 1 0 00 0 0 000000 0 0 0 0 0 00 00 00 1
002505b3 1034 1 1 0a abcd 0 000200 1034 1038 abcd 2222 0 0a 02 0b 0
0220c633 1038 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 0
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 000202 1038 103c 1111 2222 0 01 02 0c 1
00508693 103c 1 0 00 0 0 020200 103c 1040 1111 0 5 01 00 0d 0
02115733 1040 1 0 00 0 0 000204 1040 1044 2222 1111 0 02 01 0e 0
0020e7b3 1044 1 0 00 0 0 000204 1040 1044 2222 1111 0 02 01 0e 1
0020e7b3 1044 1 0 00 0 0 000204 1040 1044 2222 1111 0 02 01 0e 1
0020e7b3 1044 1 0 00 0 1 000000 0 0 0 0 0 00 00 00 0
00113833 2000 1 0 00 0 0 200200 2000 2004 2222 1111 0 02 01 10 0
002081b3 2004 1 0 00 0 1 000000 0 0 0 0 0 00 00 00 0
